// File: rtl/accel_rd_dma_sp.sv
`timescale 1ns/1ps
`include "dma_params.svh"

module accel_rd_dma_sp (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_pkg::accel_id_t        desc_accel_id,
  input  dma_pkg::byte_addr_t       desc_addr,
  input  dma_pkg::len_t             desc_len,
  input  logic                      desc_valid,
  output logic [`ACCEL_COUNT-1:0]   accel_busy,
  output mem_pkg::bank_addr_t       b0_rd_addr,
  output logic                      b0_rd_en,
  input  mem_pkg::line_t            b0_rd_data,
  output mem_pkg::bank_addr_t       b1_rd_addr,
  output logic                      b1_rd_en,
  input  mem_pkg::line_t            b1_rd_data,
  output logic [`ACCEL_COUNT*8-1:0] m_axis_tdata,
  output logic [`ACCEL_COUNT-1:0]   m_axis_tlast,
  output logic [`ACCEL_COUNT-1:0]   m_axis_tvalid,
  input  logic [`ACCEL_COUNT-1:0]   m_axis_tready,
  input  logic [`ACCEL_COUNT-1:0]   m_axis_stop
);

  localparam int META_W   = `DEST_WIDTH + 2 * `MASK_BITS + 2;
  localparam int CREDIT_W = $clog2(`FIFO_LINES) + 1;

  logic                req_v;
  dma_pkg::accel_id_t  req_dest;
  mem_pkg::line_addr_t req_addr;
  dma_pkg::byte_ptr_t  req_offset;
  dma_pkg::byte_ptr_t  req_final;
  dma_pkg::line_cnt_t  req_count;
  dma_pkg::byte_ptr_t  rem_bytes;

  mem_pkg::line_addr_t act_addr [`ACCEL_COUNT];
  dma_pkg::line_cnt_t  act_count [`ACCEL_COUNT];
  dma_pkg::byte_ptr_t  act_final [`ACCEL_COUNT];
  dma_pkg::byte_ptr_t  act_offset [`ACCEL_COUNT];
  logic [`ACCEL_COUNT-1:0] act_v;

  logic [`ACCEL_COUNT-1:0] arb_req;
  logic [`ACCEL_COUNT-1:0] grant;
  logic                    grant_valid;
  dma_pkg::accel_id_t      grant_id;
  logic [`ACCEL_COUNT-1:0] credit_ok;
  logic [`ACCEL_COUNT-1:0] pop;
  logic [`ACCEL_COUNT-1:0] stop_r;
  logic [`ACCEL_COUNT-1:0] req_onehot;
  logic [`ACCEL_COUNT-1:0] tlast_done;

  logic                issue;
  dma_pkg::accel_id_t  sel_dest;
  mem_pkg::line_addr_t sel_addr;
  mem_pkg::line_addr_t sel_addr_n;
  dma_pkg::line_cnt_t  sel_count;
  dma_pkg::byte_ptr_t  sel_final;
  dma_pkg::byte_ptr_t  sel_offset;
  dma_pkg::byte_ptr_t  sel_ptr;
  logic                sel_last;

  // Metadata riding along the read pipe, {dest, offset, ptr, last, bank}
  logic [META_W-1:0]   meta [3];
  logic                rd_v;
  logic                dat_v;
  mem_pkg::line_t      b0_data_r;
  mem_pkg::line_t      b1_data_r;
  dma_pkg::accel_id_t  m2_dest;
  dma_pkg::byte_ptr_t  m2_offset;
  dma_pkg::byte_ptr_t  m2_ptr;
  logic                m2_last;
  logic                m2_bank;
  logic [2*`DATA_WIDTH-1:0] pair;

  logic                aln_v;
  mem_pkg::line_t      aln_data;
  dma_pkg::accel_id_t  aln_dest;
  dma_pkg::byte_ptr_t  aln_ptr;
  logic                aln_last;

  assign rem_bytes = desc_len[`MASK_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      req_v <= 1'b0;
    end else begin
      req_v <= desc_valid;
    end
  end

  always_ff @(posedge clk) begin
    req_dest   <= desc_accel_id;
    req_addr   <= desc_addr[`ADDR_WIDTH-1:`MASK_BITS];
    req_offset <= desc_addr[`MASK_BITS-1:0];
    req_count  <= dma_pkg::line_cnt_t'(desc_len[`LEN_WIDTH-1:`MASK_BITS]) +
                  dma_pkg::line_cnt_t'(rem_bytes != '0);
    // A zero remainder wraps to the top byte of the line
    req_final  <= rem_bytes - 1'b1;
  end

  // New descriptors take the slot, so the arbiter stays idle then
  assign arb_req = req_v ? '0 : (act_v & credit_ok & ~stop_r);

  rr_arbiter arb (
    .clk         (clk),
    .rst         (rst),
    .request     (arb_req),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_id    (grant_id)
  );

  always_comb begin
    if (req_v) begin
      sel_dest   = req_dest;
      sel_addr   = req_addr;
      sel_count  = req_count;
      sel_final  = req_final;
      sel_offset = req_offset;
    end else begin
      sel_dest   = grant_id;
      sel_addr   = act_addr[grant_id];
      sel_count  = act_count[grant_id];
      sel_final  = act_final[grant_id];
      sel_offset = act_offset[grant_id];
    end
  end

  assign issue      = req_v || grant_valid;
  assign sel_last   = (sel_count == dma_pkg::line_cnt_t'(1));
  assign sel_ptr    = sel_last ? sel_final : '1;
  assign sel_addr_n = sel_addr + 1'b1;

  always_ff @(posedge clk) begin
    if (issue) begin
      act_addr[sel_dest]   <= sel_addr_n;
      act_count[sel_dest]  <= sel_count - 1'b1;
      act_final[sel_dest]  <= sel_final;
      act_offset[sel_dest] <= sel_offset;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_v <= '0;
    end else begin
      for (int i = 0; i < `ACCEL_COUNT; i++) begin
        if (stop_r[i]) begin
          act_v[i] <= 1'b0;
        end else if (issue && (sel_dest == dma_pkg::accel_id_t'(i))) begin
          act_v[i] <= !sel_last;
        end
      end
    end
  end

  // Line L and L+1, even lines live in bank 0
  always_ff @(posedge clk) begin
    if (rst) begin
      b0_rd_en <= 1'b0;
      b1_rd_en <= 1'b0;
    end else begin
      b0_rd_en <= issue;
      b1_rd_en <= issue;
    end
  end

  always_ff @(posedge clk) begin
    b0_rd_addr <= sel_addr[0] ? sel_addr_n[`LINE_ADDR_WIDTH-1:1] :
                                sel_addr[`LINE_ADDR_WIDTH-1:1];
    b1_rd_addr <= sel_addr[`LINE_ADDR_WIDTH-1:1];
    meta[0]    <= {sel_dest, sel_offset, sel_ptr, sel_last, sel_addr[0]};
    meta[1]    <= meta[0];
    meta[2]    <= meta[1];
    b0_data_r  <= b0_rd_data;
    b1_data_r  <= b1_rd_data;
  end

  // Reads in flight for a stopped lane are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_v  <= 1'b0;
      dat_v <= 1'b0;
      aln_v <= 1'b0;
    end else begin
      rd_v  <= b0_rd_en && !stop_r[meta[0][META_W-1 -: `DEST_WIDTH]];
      dat_v <= rd_v && !stop_r[meta[1][META_W-1 -: `DEST_WIDTH]];
      aln_v <= dat_v && !stop_r[m2_dest];
    end
  end

  assign {m2_dest, m2_offset, m2_ptr, m2_last, m2_bank} = meta[2];
  assign pair = m2_bank ? {b0_data_r, b1_data_r} : {b1_data_r, b0_data_r};

  always_ff @(posedge clk) begin
    aln_data <= mem_pkg::line_t'(pair >> {m2_offset, 3'b000});
    aln_dest <= m2_dest;
    aln_ptr  <= m2_ptr;
    aln_last <= m2_last;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stop_r <= '0;
    end else begin
      stop_r <= stop_r | m_axis_stop;
      if (desc_valid) begin
        stop_r[desc_accel_id] <= 1'b0;
      end
    end
  end

  assign req_onehot = req_v ? (`ACCEL_COUNT'(1) << req_dest) : '0;
  assign tlast_done = m_axis_tvalid & m_axis_tlast & m_axis_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      accel_busy <= '0;
    end else begin
      accel_busy <= (accel_busy | req_onehot) & ~stop_r & ~tlast_done;
    end
  end

  for (genvar i = 0; i < `ACCEL_COUNT; i++) begin : g_lane
    logic [CREDIT_W-1:0] credit;
    logic                inc;

    assign inc          = req_v ? req_onehot[i] : grant[i];
    assign credit_ok[i] = (credit < CREDIT_W'(`FIFO_LINES));

    // Lines issued but not yet popped by the lane
    always_ff @(posedge clk) begin
      if (rst || stop_r[i]) begin
        credit <= '0;
      end else if (inc && !pop[i]) begin
        credit <= credit + 1'b1;
      end else if (!inc && pop[i]) begin
        credit <= credit - 1'b1;
      end
    end

    accel_rd_lane lane (
      .clk        (clk),
      .rst        (rst),
      .clear      (stop_r[i]),
      .line_valid (aln_v && (aln_dest == dma_pkg::accel_id_t'(i))),
      .line_data  (aln_data),
      .line_last  (aln_last),
      .line_ptr   (aln_ptr),
      .pop        (pop[i]),
      .tdata      (m_axis_tdata[8*i +: 8]),
      .tlast      (m_axis_tlast[i]),
      .tvalid     (m_axis_tvalid[i]),
      .tready     (m_axis_tready[i])
    );
  end

  // Covers the two cycles before busy rises as well
  a_desc_not_busy: assert property (@(posedge clk) disable iff (rst)
    desc_valid |-> !accel_busy[desc_accel_id] && !(req_v && (req_dest == desc_accel_id)))
    else $error("descriptor sent to a busy accelerator");

  // Both banks read together, on adjacent lines L and L+1
  a_rd_en_match: assert property (@(posedge clk) disable iff (rst)
    (b0_rd_en == b1_rd_en) &&
    (!b0_rd_en || (b0_rd_addr == b1_rd_addr + meta[0][0])))
    else $error("bank reads do not cover an adjacent line pair");

endmodule

// File: rtl/accel_rd_lane.sv
`timescale 1ns/1ps
`include "dma_params.svh"

module accel_rd_lane (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear,
  input  logic               line_valid,
  input  mem_pkg::line_t     line_data,
  input  logic               line_last,
  input  dma_pkg::byte_ptr_t line_ptr,
  output logic               pop,
  output logic [7:0]         tdata,
  output logic               tlast,
  output logic               tvalid,
  input  logic               tready
);

  localparam int ENTRY_W = 1 + `MASK_BITS + `DATA_WIDTH;

  logic               fifo_valid;
  logic               fifo_last;
  dma_pkg::byte_ptr_t fifo_end;
  mem_pkg::line_t     fifo_data;
  dma_pkg::byte_ptr_t byte_ptr;
  logic               out_ready;
  logic               fire;
  logic               at_end;

  line_fifo #(
    .DEPTH (`FIFO_LINES),
    .WIDTH (ENTRY_W)
  ) fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .din        ({line_last, line_ptr, line_data}),
    .din_valid  (line_valid),
    .dout       ({fifo_last, fifo_end, fifo_data}),
    .dout_valid (fifo_valid),
    .dout_ready (pop)
  );

  // Output register is free or being drained
  assign out_ready = !tvalid || tready;
  assign fire      = fifo_valid && out_ready;
  assign at_end    = (byte_ptr == fifo_end);
  assign pop       = fire && at_end;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      byte_ptr <= '0;
      tvalid   <= 1'b0;
    end else begin
      if (fire) begin
        byte_ptr <= at_end ? '0 : byte_ptr + 1'b1;
      end
      if (out_ready) begin
        tvalid <= fifo_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      tdata <= fifo_data[{byte_ptr, 3'b000} +: 8];
      tlast <= fifo_last && at_end;
    end
  end

endmodule

// File: rtl/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Cluster size and scratchpad geometry
`define ACCEL_COUNT 4
`define LINE_BYTES  4
`define DATA_WIDTH  32
`define ADDR_WIDTH  10
`define LEN_WIDTH   8

// Lines buffered per accelerator lane
`define FIFO_LINES  2

// Derived widths
`define MASK_BITS       ($clog2(`LINE_BYTES))
`define DEST_WIDTH      ($clog2(`ACCEL_COUNT))
`define LINE_ADDR_WIDTH (`ADDR_WIDTH - `MASK_BITS)
`define BANK_ADDR_WIDTH (`LINE_ADDR_WIDTH - 1)

`endif

// File: rtl/dma_pkg.sv
`include "dma_params.svh"

package dma_pkg;

  typedef logic [`DEST_WIDTH-1:0] accel_id_t;

  // Byte address into the scratchpad
  typedef logic [`ADDR_WIDTH-1:0] byte_addr_t;

  typedef logic [`LEN_WIDTH-1:0] len_t;

  // Lines to read, one extra bit for the rounded-up count
  typedef logic [`LEN_WIDTH-`MASK_BITS:0] line_cnt_t;

  // Byte index inside a line
  typedef logic [`MASK_BITS-1:0] byte_ptr_t;

endpackage

// File: rtl/line_fifo.sv
`timescale 1ns/1ps

module line_fifo #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,
  input  logic [WIDTH-1:0] din,
  input  logic             din_valid,
  output logic [WIDTH-1:0] dout,
  output logic             dout_valid,
  input  logic             dout_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign push       = din_valid;
  assign pop        = dout_valid && dout_ready;
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Upstream credits must keep the buffer from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (rst || clear)
    din_valid |-> (count < DEPTH))
    else $error("line_fifo written while full");

endmodule

// File: rtl/mem_pkg.sv
`include "dma_params.svh"

package mem_pkg;

  // One line of one bank
  typedef logic [`DATA_WIDTH-1:0] line_t;

  // Line index inside a single bank
  typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;

  // Global line index, bit 0 picks the bank
  typedef logic [`LINE_ADDR_WIDTH-1:0] line_addr_t;

endpackage

// File: rtl/rd_dma_top.sv
`timescale 1ns/1ps
`include "dma_params.svh"

module rd_dma_top (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_pkg::accel_id_t        desc_accel_id,
  input  dma_pkg::byte_addr_t       desc_addr,
  input  dma_pkg::len_t             desc_len,
  input  logic                      desc_valid,
  output logic [`ACCEL_COUNT-1:0]   accel_busy,
  output logic [`ACCEL_COUNT*8-1:0] m_axis_tdata,
  output logic [`ACCEL_COUNT-1:0]   m_axis_tlast,
  output logic [`ACCEL_COUNT-1:0]   m_axis_tvalid,
  input  logic [`ACCEL_COUNT-1:0]   m_axis_tready,
  input  logic [`ACCEL_COUNT-1:0]   m_axis_stop,
  input  logic                      wr_en,
  input  mem_pkg::line_addr_t       wr_line_addr,
  input  mem_pkg::line_t            wr_data
);

  mem_pkg::bank_addr_t b0_rd_addr;
  mem_pkg::bank_addr_t b1_rd_addr;
  logic                b0_rd_en;
  logic                b1_rd_en;
  mem_pkg::line_t      b0_rd_data;
  mem_pkg::line_t      b1_rd_data;

  accel_rd_dma_sp dma (
    .clk           (clk),
    .rst           (rst),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid),
    .accel_busy    (accel_busy),
    .b0_rd_addr    (b0_rd_addr),
    .b0_rd_en      (b0_rd_en),
    .b0_rd_data    (b0_rd_data),
    .b1_rd_addr    (b1_rd_addr),
    .b1_rd_en      (b1_rd_en),
    .b1_rd_data    (b1_rd_data),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_stop   (m_axis_stop)
  );

  scratchpad_banks spad (
    .clk          (clk),
    .b0_rd_addr   (b0_rd_addr),
    .b0_rd_en     (b0_rd_en),
    .b0_rd_data   (b0_rd_data),
    .b1_rd_addr   (b1_rd_addr),
    .b1_rd_en     (b1_rd_en),
    .b1_rd_data   (b1_rd_data),
    .wr_en        (wr_en),
    .wr_line_addr (wr_line_addr),
    .wr_data      (wr_data)
  );

endmodule

// File: rtl/rr_arbiter.sv
`timescale 1ns/1ps
`include "dma_params.svh"

module rr_arbiter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`ACCEL_COUNT-1:0] request,
  output logic [`ACCEL_COUNT-1:0] grant,
  output logic                    grant_valid,
  output dma_pkg::accel_id_t      grant_id
);

  // Last winner gets lowest priority next time
  dma_pkg::accel_id_t last_id;

  always_comb begin
    dma_pkg::accel_id_t idx;
    grant_valid = 1'b0;
    grant_id    = '0;
    for (int i = 1; i <= `ACCEL_COUNT; i++) begin
      idx = dma_pkg::accel_id_t'((int'(last_id) + i) % `ACCEL_COUNT);
      if (!grant_valid && request[idx]) begin
        grant_valid = 1'b1;
        grant_id    = idx;
      end
    end
    grant = grant_valid ? (`ACCEL_COUNT'(1) << grant_id) : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_id <= dma_pkg::accel_id_t'(`ACCEL_COUNT - 1);
    end else if (grant_valid) begin
      last_id <= grant_id;
    end
  end

endmodule

// File: rtl/scratchpad_banks.sv
`timescale 1ns/1ps
`include "dma_params.svh"

module scratchpad_banks (
  input  logic                clk,
  input  mem_pkg::bank_addr_t b0_rd_addr,
  input  logic                b0_rd_en,
  output mem_pkg::line_t      b0_rd_data,
  input  mem_pkg::bank_addr_t b1_rd_addr,
  input  logic                b1_rd_en,
  output mem_pkg::line_t      b1_rd_data,
  input  logic                wr_en,
  input  mem_pkg::line_addr_t wr_line_addr,
  input  mem_pkg::line_t      wr_data
);

  localparam int BANK_LINES = 2 ** `BANK_ADDR_WIDTH;

  mem_pkg::line_t      mem [2][BANK_LINES];
  mem_pkg::bank_addr_t rd_addr [2];
  logic [1:0]          rd_en;
  mem_pkg::line_t      rd_data [2];
  mem_pkg::bank_addr_t wr_bank_addr;

  assign rd_addr[0]   = b0_rd_addr;
  assign rd_addr[1]   = b1_rd_addr;
  assign rd_en        = {b1_rd_en, b0_rd_en};
  assign b0_rd_data   = rd_data[0];
  assign b1_rd_data   = rd_data[1];
  assign wr_bank_addr = wr_line_addr[`LINE_ADDR_WIDTH-1:1];

  // Low bit of the line address picks the bank
  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (rd_en[b]) begin
        rd_data[b] <= mem[b][rd_addr[b]];
      end
      if (wr_en && (wr_line_addr[0] == b[0])) begin
        mem[b][wr_bank_addr] <= wr_data;
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run tb_rd_dma with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rd_dma -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rd_dma)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: testbench/rd_dma_stim.txt
# One command per line, all fields in hex
#   P xor | D accel addr len | S accel | R ready_mask | W cycles
# P preloads each byte as its address low byte XOR xor, R sets lanes with random tready
P 5A
# Aligned starts, whole lines
D 0 000 10
D 1 040 04
D 2 104 40
W 30
# Unaligned starts, bank crossings, short tails
D 0 003 01
D 1 005 07
D 2 01E 0B
D 3 0FF 21
W 40
D 0 3F9 06
D 1 00D 02
D 3 2F1 0F
W 40
# All four lanes at once
D 0 200 40
D 1 013 31
D 2 0A6 27
D 3 301 5A
W 80
# Back-pressure on some lanes
R 5
D 0 15B 63
D 1 0C0 40
D 2 2E7 FF
D 3 37A 11
W A0
R F
D 0 050 2D
D 3 111 81
W 20
R 0
# Stop mid transfer, then reuse the lane
D 1 080 C8
W 14
S 1
D 1 081 23
R 4
D 2 010 C0
W 18
S 2
D 2 3C2 3D
R 0

// File: testbench/tb_rd_dma.sv
`timescale 1ns/1ps
`include "dma_params.svh"

module tb_rd_dma;

  localparam int N           = `ACCEL_COUNT;
  localparam int LINES       = 2 ** `LINE_ADDR_WIDTH;
  localparam int DRAIN_LIMIT = 4000;

  logic                clk;
  logic                rst;
  dma_pkg::accel_id_t  desc_accel_id;
  dma_pkg::byte_addr_t desc_addr;
  dma_pkg::len_t       desc_len;
  logic                desc_valid;
  logic [N-1:0]        accel_busy;
  logic [N*8-1:0]      m_axis_tdata;
  logic [N-1:0]        m_axis_tlast;
  logic [N-1:0]        m_axis_tvalid;
  logic [N-1:0]        m_axis_tready;
  logic [N-1:0]        m_axis_stop;
  logic                wr_en;
  mem_pkg::line_addr_t wr_line_addr;
  mem_pkg::line_t      wr_data;

  // Expected {tlast, byte} per lane, one descriptor deep
  logic [8:0]   exp_mem [N][256];
  int           head [N];
  int           tail [N];
  logic [7:0]   pat;
  logic [N-1:0] rand_mask;
  int           errors;
  int           checked;
  bit           timed_out;

  rd_dma_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Scratchpad contents by address
  function automatic logic [7:0] pattern_byte(input int addr);
    return addr[7:0] ^ pat;
  endfunction

  // Lanes set in rand_mask get random back-pressure
  initial begin
    logic [31:0] lfsr;
    lfsr = 32'h5223ea97;
    m_axis_tready = '1;
    forever begin
      @(negedge clk);
      for (int i = 0; i < N; i++) begin
        if (rand_mask[i]) begin
          lfsr = lfsr_next(lfsr);
          m_axis_tready[i] = lfsr[0];
        end else begin
          m_axis_tready[i] = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    logic [8:0] got;
    if (!rst) begin
      for (int i = 0; i < N; i++) begin
        got = {m_axis_tlast[i], m_axis_tdata[8*i +: 8]};
        if (m_axis_tvalid[i] && m_axis_tready[i]) begin
          if (head[i] == tail[i]) begin
            errors++;
            $display("Error at time %0t: lane %0d sent %h with no byte expected",
                     $time, i, got[7:0]);
          end else begin
            checked++;
            if (got !== exp_mem[i][head[i]]) begin
              errors++;
              $display("Error at time %0t: lane %0d byte %0d is %h last %b, expected %h last %b",
                       $time, i, head[i], got[7:0], got[8],
                       exp_mem[i][head[i]][7:0], exp_mem[i][head[i]][8]);
            end
            head[i]++;
          end
        end
      end
    end
  end

  task automatic preload(input logic [7:0] x);
    pat = x;
    for (int l = 0; l < LINES; l++) begin
      wr_en        = 1'b1;
      wr_line_addr = mem_pkg::line_addr_t'(l);
      for (int j = 0; j < `LINE_BYTES; j++) begin
        wr_data[8*j +: 8] = pattern_byte(l * `LINE_BYTES + j);
      end
      @(negedge clk);
    end
    wr_en = 1'b0;
  endtask

  task automatic wait_drain(input int a);
    int cnt;
    cnt = 0;
    while ((head[a] != tail[a]) && (cnt < DRAIN_LIMIT)) begin
      @(negedge clk);
      cnt++;
    end
    if (head[a] != tail[a]) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: lane %0d still owed %0d bytes after %0d cycles",
               a, tail[a] - head[a], DRAIN_LIMIT);
    end else if (accel_busy[a]) begin
      errors++;
      $display("Error at time %0t: lane %0d still busy after its stream drained", $time, a);
    end
  endtask

  task automatic send_desc(input int a, input int addr, input int len);
    wait_drain(a);
    if (!timed_out) begin
      head[a] = 0;
      for (int k = 0; k < len; k++) begin
        exp_mem[a][k] = {k == len - 1, pattern_byte(addr + k)};
      end
      tail[a]       = len;
      desc_accel_id = dma_pkg::accel_id_t'(a);
      desc_addr     = dma_pkg::byte_addr_t'(addr);
      desc_len      = dma_pkg::len_t'(len);
      desc_valid    = 1'b1;
      @(negedge clk);
      desc_valid = 1'b0;
      @(negedge clk);
      if (!accel_busy[a]) begin
        errors++;
        $display("Error at time %0t: lane %0d not busy 2 cycles after its descriptor",
                 $time, a);
      end
    end
  endtask

  task automatic stop_lane(input int a);
    int late;
    late = 0;
    m_axis_stop[a] = 1'b1;
    @(negedge clk);
    m_axis_stop[a] = 1'b0;
    repeat (2) @(negedge clk);
    // Bytes taken up to here were a correct prefix, the rest is dropped
    head[a] = tail[a];
    if (accel_busy[a]) begin
      errors++;
      $display("Error at time %0t: lane %0d still busy after stop", $time, a);
    end
    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      if (m_axis_tvalid[a]) begin
        late++;
      end
    end
    if (late != 0) begin
      errors++;
      $display("Error at time %0t: lane %0d showed tvalid in %0d cycles after stop",
               $time, a, late);
    end
  endtask

  initial begin
    int    fd;
    int    code;
    int    a;
    int    b;
    int    c;
    byte   op;
    string text;
    errors        = 0;
    checked       = 0;
    timed_out     = 1'b0;
    rand_mask     = '0;
    pat           = '0;
    rst           = 1'b1;
    desc_accel_id = '0;
    desc_addr     = '0;
    desc_len      = '0;
    desc_valid    = 1'b0;
    m_axis_stop   = '0;
    wr_en         = 1'b0;
    wr_line_addr  = '0;
    wr_data       = '0;
    for (int i = 0; i < N; i++) begin
      head[i] = 0;
      tail[i] = 0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if ((accel_busy !== '0) || (m_axis_tvalid !== '0)) begin
      errors++;
      $display("Error at time %0t: busy or tvalid set after reset", $time);
    end
    fd = $fopen("testbench/rd_dma_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file testbench/rd_dma_stim.txt");
    end else begin
      while (!timed_out && !$feof(fd)) begin
        code = $fgets(text, fd);
        if ((code > 0) && (text.len() > 1) && (text.getc(0) != "#")) begin
          op   = text.getc(0);
          a    = 0;
          b    = 0;
          c    = 0;
          code = $sscanf(text.substr(1, text.len() - 1), "%h %h %h", a, b, c);
          case (op)
            "P": preload(a[7:0]);
            "D": send_desc(a, b, c);
            "S": stop_lane(a);
            "R": rand_mask = a[N-1:0];
            "W": repeat (a) @(negedge clk);
            default: begin
              errors++;
              $display("Unknown command in stimulus file: %s", text);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    for (int i = 0; (i < N) && !timed_out; i++) begin
      wait_drain(i);
    end
    $display("Compared %0d bytes, found %0d errors", checked, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/dma_pkg.sv
rtl/rr_arbiter.sv
rtl/line_fifo.sv
rtl/accel_rd_lane.sv
rtl/accel_rd_dma_sp.sv
rtl/scratchpad_banks.sv
rtl/rd_dma_top.sv
testbench/tb_rd_dma.sv
